/* sources.f */
rtl/stats_pkg.sv
rtl/pause_pkg.sv
rtl/stats_serializer.sv
rtl/pause_deserializer.sv
rtl/mac_sideband_top.sv
verification/mac_sideband_asserts.sv
verification/tb_mac_sideband.sv

/* Makefile */
TOP := tb_mac_sideband

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/tb_mac_sideband.sv */
`timescale 1ns/1ns

module tb_mac_sideband;

    import stats_pkg::*;
    import pause_pkg::*;

    // reset 8, idle 40, rx 330, tx 410, restart 230, pause 390, bad pause 195
    localparam int timeout_cycles = 2000;

    logic          gtx_clk_bufg = 1'b0;
    logic          reset;
    rx_stats_t     rx_statistics_vector;
    logic          rx_statistics_valid;
    tx_stats_t     tx_statistics_vector;
    logic          tx_statistics_valid;
    logic          pause_req_s;
    logic          rx_statistics_s;
    logic          tx_statistics_s;
    logic          pause_req;
    pause_quanta_t pause_val;

    int unsigned   cycle_count = 0;
    int unsigned   fails_before = 0;  // assertion failures before the current test
    int unsigned   tests_passed = 0;
    int unsigned   tests_failed = 0;
    logic [31:0]   rnd;

    mac_sideband_top i_dut (
        .gtx_clk_bufg         (gtx_clk_bufg),
        .reset                (reset),
        .rx_statistics_vector (rx_statistics_vector),
        .rx_statistics_valid  (rx_statistics_valid),
        .tx_statistics_vector (tx_statistics_vector),
        .tx_statistics_valid  (tx_statistics_valid),
        .pause_req_s          (pause_req_s),
        .rx_statistics_s      (rx_statistics_s),
        .tx_statistics_s      (tx_statistics_s),
        .pause_req            (pause_req),
        .pause_val            (pause_val)
    );

    always #5 gtx_clk_bufg = ~gtx_clk_bufg;  // 10 ns period

    // ----------------------------------------
    // run limit
    // ----------------------------------------
    always @(posedge gtx_clk_bufg) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("run stopped: tests did not finish within %0d cycles", timeout_cycles);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge gtx_clk_bufg);
    endtask

    // valid high for hold cycles, vector set on the first
    task automatic send_rx_stats(input rx_stats_t vec, input int hold);
        @(posedge gtx_clk_bufg);
        rx_statistics_vector <= vec;
        rx_statistics_valid  <= 1'b1;
        wait_cycles(hold);
        rx_statistics_valid  <= 1'b0;
    endtask

    task automatic send_tx_stats(input tx_stats_t vec, input int hold);
        @(posedge gtx_clk_bufg);
        tx_statistics_vector <= vec;
        tx_statistics_valid  <= 1'b1;
        wait_cycles(hold);
        tx_statistics_valid  <= 1'b0;
    endtask

    // start bit, quanta msb first, stop bit, then back to idle
    task automatic send_pause_frame(input pause_quanta_t quanta, input logic stop_bit);
        logic [pause_quanta_width+1:0] bits;
        bits = {1'b1, quanta, stop_bit};
        repeat (pause_quanta_width + 2) begin
            @(posedge gtx_clk_bufg);
            pause_req_s <= bits[pause_quanta_width+1];
            bits = bits << 1;
        end
        @(posedge gtx_clk_bufg);
        pause_req_s <= 1'b0;
        wait_cycles(20);  // request lands 18 edges after the start bit
    endtask

    task automatic report_test(input string name);
        int unsigned seen;
        seen = i_dut.i_asserts.fail_count - fails_before;
        if (seen == 0) begin
            $display("pass  %s", name);
            tests_passed = tests_passed + 1;
        end else begin
            $display("error %0t ns: %s, %0d assertion failures", $time, name, seen);
            tests_failed = tests_failed + 1;
        end
        fails_before = i_dut.i_asserts.fail_count;
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        rnd                  = $urandom(55448);  // seed once
        reset                = 1'b1;
        rx_statistics_vector = '0;
        rx_statistics_valid  = 1'b0;
        tx_statistics_vector = '0;
        tx_statistics_valid  = 1'b0;
        pause_req_s          = 1'b0;
        wait_cycles(8);
        reset <= 1'b0;

        wait_cycles(40);  // all inputs idle
        report_test("idle after reset");

        repeat (10) begin
            rnd = $urandom();
            send_rx_stats(rnd[rx_stats_width-1:0], 1);
            wait_cycles(rx_stats_width + 3);
        end
        report_test("rx frame");

        // msb forced low so a second load would show up as a stray start bit
        repeat (10) begin
            rnd = $urandom();
            send_tx_stats({1'b0, rnd[tx_stats_width-2:0]}, 5);
            wait_cycles(tx_stats_width + 3);
        end
        report_test("tx frame with held valid");

        repeat (5) begin
            rnd = $urandom();
            send_rx_stats(rnd[rx_stats_width-1:0], 1);
            wait_cycles(11);  // mid frame
            rnd = $urandom();
            send_rx_stats(rnd[rx_stats_width-1:0], 1);
            wait_cycles(rx_stats_width + 3);
        end
        report_test("rx restart");

        repeat (10) begin
            rnd = $urandom();
            send_pause_frame(rnd[pause_quanta_width-1:0], 1'b1);
        end
        report_test("pause frame");

        repeat (5) begin
            rnd = $urandom();
            send_pause_frame(rnd[pause_quanta_width-1:0], 1'b0);  // broken stop bit
        end
        report_test("bad pause frame");

        $display("tests %0d, passed %0d, failed %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (tests_failed == 0 && i_dut.i_asserts.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : tb_mac_sideband

/* verification/mac_sideband_asserts.sv */
`timescale 1ns/1ns

module mac_sideband_asserts (
    input  logic                     gtx_clk_bufg,
    input  logic                     reset,
    input  stats_pkg::rx_stats_t     rx_statistics_vector,
    input  logic                     rx_statistics_valid,
    input  stats_pkg::tx_stats_t     tx_statistics_vector,
    input  logic                     tx_statistics_valid,
    input  logic                     pause_req_s,
    input  logic                     rx_statistics_s,
    input  logic                     tx_statistics_s,
    input  logic                     pause_req,
    input  pause_pkg::pause_quanta_t pause_val
);

    import stats_pkg::*;
    import pause_pkg::*;

    localparam int rx_frame = rx_stats_width + stats_frame_overhead;  // 30 cycles
    localparam int tx_frame = tx_stats_width + stats_frame_overhead;  // 34 cycles

    int unsigned fail_count = 0;  // read by the testbench after each test

    // bump the count and raise an error
    task automatic flag_failure(input string msg);
        fail_count = fail_count + 1;
        $error("%s", msg);
    endtask

    // ----------------------------------------
    // frame age since the last valid edge
    // ----------------------------------------
    // age 1 is the start bit, then the vector msb first, then the stop bit
    logic      rx_valid_q;
    logic      tx_valid_q;
    int        rx_age;
    int        tx_age;
    rx_stats_t rx_cap;      // vector taken at the edge
    tx_stats_t tx_cap;
    rx_stats_t rx_aligned;  // expected bit sits in the msb
    tx_stats_t tx_aligned;

    always_ff @(posedge gtx_clk_bufg) begin
        if (reset) begin
            rx_valid_q <= 1'b0;  // valid high at release still counts
            tx_valid_q <= 1'b0;
            rx_age     <= rx_frame + 1;  // idle
            tx_age     <= tx_frame + 1;
            rx_cap     <= '0;
            tx_cap     <= '0;
        end else begin
            rx_valid_q <= rx_statistics_valid;
            tx_valid_q <= tx_statistics_valid;
            if (rx_statistics_valid && !rx_valid_q) begin
                rx_age <= 1;  // new frame, also mid frame
                rx_cap <= rx_statistics_vector;
            end else if (rx_age <= rx_frame) begin
                rx_age <= rx_age + 1;  // saturates at idle
            end
            if (tx_statistics_valid && !tx_valid_q) begin
                tx_age <= 1;
                tx_cap <= tx_statistics_vector;
            end else if (tx_age <= tx_frame) begin
                tx_age <= tx_age + 1;
            end
        end
    end

    assign rx_aligned = rx_cap << (rx_age - 2);
    assign tx_aligned = tx_cap << (tx_age - 2);

    // ----------------------------------------
    // pause line history
    // ----------------------------------------
    // bit 0 is the line one edge ago, top bit twenty edges ago
    logic [pause_frame_width:0] line_hist;
    logic                       pause_expect;
    pause_quanta_t              quanta_expect;

    always_ff @(posedge gtx_clk_bufg) begin
        if (reset) begin
            line_hist <= '0;
        end else begin
            line_hist <= {line_hist[pause_frame_width-1:0], pause_req_s};
        end
    end

    // idle zero, start one, quanta, stop one
    assign pause_expect  = ~line_hist[pause_frame_width]
                         &  line_hist[pause_frame_width-1]
                         &  line_hist[1];
    assign quanta_expect = pause_expect ? line_hist[pause_quanta_width+1:2] : '0;

    // ----------------------------------------
    // statistics frames
    // ----------------------------------------
    a_rx_markers: assert property (@(posedge gtx_clk_bufg) disable iff (reset)
        (rx_age == 1 || rx_age == rx_frame) |-> rx_statistics_s)
        else flag_failure("rx start or stop bit low");

    a_rx_data: assert property (@(posedge gtx_clk_bufg) disable iff (reset)
        (rx_age >= 2 && rx_age <= rx_stats_width + 1)
            |-> rx_statistics_s == rx_aligned[rx_stats_width-1])
        else flag_failure("rx vector bit wrong");

    a_rx_idle: assert property (@(posedge gtx_clk_bufg) disable iff (reset)
        rx_age > rx_frame |-> !rx_statistics_s)
        else flag_failure("rx pin high while idle");

    a_tx_markers: assert property (@(posedge gtx_clk_bufg) disable iff (reset)
        (tx_age == 1 || tx_age == tx_frame) |-> tx_statistics_s)
        else flag_failure("tx start or stop bit low");

    a_tx_data: assert property (@(posedge gtx_clk_bufg) disable iff (reset)
        (tx_age >= 2 && tx_age <= tx_stats_width + 1)
            |-> tx_statistics_s == tx_aligned[tx_stats_width-1])
        else flag_failure("tx vector bit wrong");

    a_tx_idle: assert property (@(posedge gtx_clk_bufg) disable iff (reset)
        tx_age > tx_frame |-> !tx_statistics_s)
        else flag_failure("tx pin high while idle");

    // ----------------------------------------
    // pause request
    // ----------------------------------------
    a_pause_req: assert property (@(posedge gtx_clk_bufg) disable iff (reset)
        pause_req == pause_expect)
        else flag_failure("pause_req mismatch");

    a_pause_val: assert property (@(posedge gtx_clk_bufg) disable iff (reset)
        pause_val == quanta_expect)
        else flag_failure("pause_val mismatch");

endmodule : mac_sideband_asserts

bind mac_sideband_top mac_sideband_asserts i_asserts (
    .gtx_clk_bufg         (gtx_clk_bufg),
    .reset                (reset),
    .rx_statistics_vector (rx_statistics_vector),
    .rx_statistics_valid  (rx_statistics_valid),
    .tx_statistics_vector (tx_statistics_vector),
    .tx_statistics_valid  (tx_statistics_valid),
    .pause_req_s          (pause_req_s),
    .rx_statistics_s      (rx_statistics_s),
    .tx_statistics_s      (tx_statistics_s),
    .pause_req            (pause_req),
    .pause_val            (pause_val)
);

/* rtl/mac_sideband_top.sv */
`timescale 1ns/1ns

module mac_sideband_top #(
    parameter int rx_width     = stats_pkg::rx_stats_width,     // rx vector bits
    parameter int tx_width     = stats_pkg::tx_stats_width,     // tx vector bits
    parameter int quanta_width = pause_pkg::pause_quanta_width  // pause quanta bits
) (
    input  logic                     gtx_clk_bufg,          // single clock domain
    input  logic                     reset,                 // sync, active high

    // rx statistics from the mac
    input  stats_pkg::rx_stats_t     rx_statistics_vector,
    input  logic                     rx_statistics_valid,

    // tx statistics from the mac
    input  stats_pkg::tx_stats_t     tx_statistics_vector,
    input  logic                     tx_statistics_valid,

    // serial pause control in
    input  logic                     pause_req_s,

    // serial statistics out
    output logic                     rx_statistics_s,
    output logic                     tx_statistics_s,

    // parallel pause request out
    output logic                     pause_req,
    output pause_pkg::pause_quanta_t pause_val
);

    // ----------------------------------------
    // input side
    // ----------------------------------------
    // serial pause line back to a request plus quanta
    pause_deserializer #(
        .quanta_width (quanta_width)
    ) i_pause (
        .gtx_clk_bufg (gtx_clk_bufg),
        .reset        (reset),
        .pause_req_s  (pause_req_s),
        .pause_req    (pause_req),  // one cycle pulse
        .pause_val    (pause_val)   // zero outside the pulse
    );

    // ----------------------------------------
    // rx statistics engine
    // ----------------------------------------
    // 28 bit vector, 30 cycle frame
    stats_serializer #(
        .vector_width (rx_width)
    ) i_rx_stats (
        .gtx_clk_bufg (gtx_clk_bufg),
        .reset        (reset),
        .stats_vector (rx_statistics_vector),
        .stats_valid  (rx_statistics_valid),  // rising edge loads
        .stats_s      (rx_statistics_s)       // driven straight from the shifter
    );

    // ----------------------------------------
    // tx statistics engine
    // ----------------------------------------
    // 32 bit vector, 34 cycle frame
    stats_serializer #(
        .vector_width (tx_width)
    ) i_tx_stats (
        .gtx_clk_bufg (gtx_clk_bufg),
        .reset        (reset),
        .stats_vector (tx_statistics_vector),
        .stats_valid  (tx_statistics_valid),  // rising edge loads
        .stats_s      (tx_statistics_s)
    );

    // no registers here
    // all output timing comes from the engines above

endmodule : mac_sideband_top

/* rtl/pause_deserializer.sv */
`timescale 1ns/1ns

module pause_deserializer #(
    parameter int quanta_width = 16  // pause quanta bits
) (
    input  logic                    gtx_clk_bufg,
    input  logic                    reset,        // sync, active high
    input  logic                    pause_req_s,  // serial pause line, idles low
    output logic                    pause_req,    // one cycle request
    output logic [quanta_width-1:0] pause_val     // quanta, zero when no request
);

    import pause_pkg::*;

    // window is the quanta plus the idle, start and stop positions
    localparam int window_width = quanta_width + (pause_frame_width - pause_quanta_width);

    // ----------------------------------------
    // serial window
    // ----------------------------------------
    logic [window_width-1:0] pause_shift;  // newest bit at the bottom
    logic                    frame_match;  // idle, start and stop all in place

    always_ff @(posedge gtx_clk_bufg) begin
        if (reset) begin
            pause_shift <= '0;
        end else begin
            pause_shift <= {pause_shift[window_width-2:0], pause_req_s};
        end
    end

    // ----------------------------------------
    // frame match
    // ----------------------------------------
    // top bit is the idle zero sampled before the start bit
    // next bit down is the start bit
    // bottom bit is the stop bit sampled last
    assign frame_match = ~pause_shift[window_width-1]
                       &  pause_shift[window_width-2]
                       &  pause_shift[0];

    // ----------------------------------------
    // registered request and quanta
    // ----------------------------------------
    // request lands one edge after the match
    // i.e. 18 edges after the start bit for a 16 bit quanta
    always_ff @(posedge gtx_clk_bufg) begin
        if (reset) begin
            pause_req <= 1'b0;
            pause_val <= '0;
        end else if (frame_match) begin
            pause_req <= 1'b1;
            pause_val <= pause_shift[quanta_width:1];  // bits between start and stop
        end else begin
            pause_req <= 1'b0;
            pause_val <= '0;  // value only valid alongside the request
        end
    end

    // a zero in the stop position never matches
    // so a broken frame produces no request at all

endmodule : pause_deserializer

/* rtl/stats_serializer.sv */
`timescale 1ns/1ns

module stats_serializer #(
    parameter int vector_width = 28  // statistics vector bits
) (
    input  logic                    gtx_clk_bufg,
    input  logic                    reset,         // sync, active high
    input  logic [vector_width-1:0] stats_vector,  // sampled on valid rising edge
    input  logic                    stats_valid,   // strobe or level from the mac
    output logic                    stats_s        // framed serial stats
);

    import stats_pkg::*;

    // shifter holds start marker, vector and stop marker
    localparam int shift_width = vector_width + stats_frame_overhead;

    // ----------------------------------------
    // valid edge detect
    // ----------------------------------------
    logic                   valid_reg;    // valid delayed one cycle
    logic                   valid_rise;   // first cycle of valid high
    logic [shift_width-1:0] stats_shift;  // output shifter, msb goes out first

    // cleared in reset so a valid already high at release counts as an edge
    always_ff @(posedge gtx_clk_bufg) begin
        if (reset) begin
            valid_reg <= 1'b0;
        end else begin
            valid_reg <= stats_valid;
        end
    end

    assign valid_rise = stats_valid & ~valid_reg;  // held valid loads only once

    // ----------------------------------------
    // capture and shift
    // ----------------------------------------
    // the shifter runs every cycle
    // zeros fill in from the bottom so the pin idles low after the stop bit
    always_ff @(posedge gtx_clk_bufg) begin
        if (reset) begin
            stats_shift <= '0;
        end else if (valid_rise) begin
            // start bit, vector msb first, stop bit
            // a new edge mid frame simply reloads
            stats_shift <= {1'b1, stats_vector, 1'b1};
        end else begin
            stats_shift <= {stats_shift[shift_width-2:0], 1'b0};  // shift toward msb
        end
    end

    // ----------------------------------------
    // serial out
    // ----------------------------------------
    // start bit appears the cycle after the valid edge
    // frame lasts vector_width + 2 cycles
    assign stats_s = stats_shift[shift_width-1];

endmodule : stats_serializer

/* rtl/pause_pkg.sv */
package pause_pkg;

    // ----------------------------------------
    // pause quanta
    // ----------------------------------------
    localparam int pause_quanta_width = 16;  // quanta in 512 bit-time units

    typedef logic [pause_quanta_width-1:0] pause_quanta_t;

    // ----------------------------------------
    // serial frame window
    // ----------------------------------------
    // idle zero, start bit, quanta msb first, stop bit
    // so three marker positions wrap the quanta
    localparam int pause_frame_width = pause_quanta_width + 3;

    // the line idles at zero, the start bit is a one
    // and the stop bit is a one

endpackage : pause_pkg

/* rtl/stats_pkg.sv */
package stats_pkg;

    // ----------------------------------------
    // statistics vector widths
    // ----------------------------------------
    localparam int rx_stats_width = 28;  // rx stats from the mac core
    localparam int tx_stats_width = 32;  // tx stats from the mac core

    // ----------------------------------------
    // serial frame
    // ----------------------------------------
    // one start marker ahead of the vector and one stop marker behind it
    localparam int stats_frame_overhead = 2;

    // ----------------------------------------
    // vector types
    // ----------------------------------------
    typedef logic [rx_stats_width-1:0] rx_stats_t;  // receive side vector
    typedef logic [tx_stats_width-1:0] tx_stats_t;  // transmit side vector

    // both serial pins idle low between frames

endpackage : stats_pkg
